/* vlane_pkg.sv */
package vlane_pkg;

    //////////////////////////////////////////////////
    // Default sizes, overridden from the top level
    parameter int LANE_NUM        = 8;
    parameter int MEM_DEPTH       = 512;  // VRF words per lane
    parameter int MAX_VL_PER_LANE = 256;

    //////////////////////////////////////////////////
    // Fixed by the VRF
    parameter int RD_PORTS       = 3;  // vs1, vs2, vs3
    parameter int BYTES_PER_WORD = 4;

    //////////////////////////////////////////////////
    // Instruction kinds
    typedef enum logic [1:0] {
        NORMAL,  // Read, then write after the pipe delay
        STORE,   // Read only, data to the store unit
        LOAD     // Write only, data from the load unit
    } inst_type_e;

    // Element width codes
    typedef enum logic [1:0] {
        EW_BYTE = 2'd0,
        EW_HALF = 2'd1,
        EW_WORD = 2'd2
    } elem_width_e;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        DISPATCH,
        NORMAL_MODE,
        READ_MODE,
        LOAD_MODE
    } seq_state_e;

endpackage

/* addr_ctrl_if.sv */
`timescale 1ns/1ps

// Address counter control, sampled by the generator on every rising edge
interface addr_ctrl_if;

    logic                   load;      // Copy start addresses, clear counts
    logic                   rd_step;   // Advance the shared read count
    logic                   wr_step;   // Advance the write count
    vlane_pkg::elem_width_e rd_width;
    vlane_pkg::elem_width_e wr_width;

    modport seq (
        output load, rd_step, wr_step, rd_width, wr_width
    );

    modport gen (
        input load, rd_step, wr_step, rd_width, wr_width
    );

endinterface

/* lane_sequencer.sv */
`timescale 1ns/1ps

module lane_sequencer #(
    parameter int MAX_VL_PER_LANE = vlane_pkg::MAX_VL_PER_LANE,
    parameter int LANE_NUM        = vlane_pkg::LANE_NUM,
    localparam int VL_W = $clog2(LANE_NUM * MAX_VL_PER_LANE + 1),
    localparam int DL_W = $clog2(MAX_VL_PER_LANE)
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  vlane_pkg::inst_type_e  inst_type_i,
    input  logic [VL_W-1:0]        vl_i,
    input  vlane_pkg::elem_width_e vsew_i,
    input  vlane_pkg::elem_width_e wdata_width_i,
    input  logic [DL_W-1:0]        inst_delay_i,
    input  logic                   load_valid_i,
    input  logic                   load_last_i,
    output logic                   ready_o,
    output logic                   store_data_valid_o,
    output logic                   ready_for_load_o,
    output logic                   wr_active_o,
    output logic                   load_phase_o,
    output logic                   rd_active_o,
    output logic                   rd_clear_o,
    addr_ctrl_if.seq               actl
);

    localparam int LSH   = $clog2(LANE_NUM);
    localparam int LEN_W = $clog2(MAX_VL_PER_LANE + 1);
    localparam int CNT_W = $clog2(2 * MAX_VL_PER_LANE) + 1;  // Covers delay plus length

    vlane_pkg::seq_state_e  state_q, state_d;
    vlane_pkg::inst_type_e  inst_q;
    vlane_pkg::elem_width_e rd_width_q, wr_width_q;
    logic [LEN_W-1:0] len_q;   // Read cycles per lane
    logic [DL_W-1:0]  delay_q;
    logic [CNT_W-1:0] cnt_q;   // Phase counter
    logic [CNT_W-1:0] wr_end;
    logic [VL_W:0]    vl_round;
    logic accept;
    logic rd_win, wr_win;
    logic rd_active_q, wr_active_q, store_q, load_q;

    assign accept   = start_i && ready_o;
    assign vl_round = {1'b0, vl_i} + (VL_W + 1)'(LANE_NUM - 1);
    assign wr_end   = CNT_W'(delay_q) + CNT_W'(len_q);

    //////////////////////////////////////////////////
    // Instruction latch

    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q     <= inst_type_i;
            len_q      <= LEN_W'(vl_round >> LSH);  // ceil(vl / lanes)
            delay_q    <= inst_delay_i;
            rd_width_q <= (inst_type_i == vlane_pkg::STORE) ? vlane_pkg::EW_WORD : vsew_i;
            wr_width_q <= (inst_type_i == vlane_pkg::LOAD) ? vlane_pkg::EW_WORD : wdata_width_i;
        end
    end

    //////////////////////////////////////////////////
    // Mode FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            vlane_pkg::IDLE: if (accept) state_d = vlane_pkg::DISPATCH;
            vlane_pkg::DISPATCH: begin
                case (inst_q)
                    vlane_pkg::NORMAL: state_d = vlane_pkg::NORMAL_MODE;
                    vlane_pkg::STORE:  state_d = vlane_pkg::READ_MODE;
                    vlane_pkg::LOAD:   state_d = vlane_pkg::LOAD_MODE;
                    default:           state_d = vlane_pkg::IDLE;
                endcase
            end
            vlane_pkg::NORMAL_MODE: if (cnt_q == wr_end) state_d = vlane_pkg::IDLE;
            vlane_pkg::READ_MODE: if (cnt_q == CNT_W'(len_q)) state_d = vlane_pkg::IDLE;
            vlane_pkg::LOAD_MODE: if (load_q && load_last_i) state_d = vlane_pkg::IDLE;
            default: state_d = vlane_pkg::IDLE;
        endcase
    end

    // Phase windows, seen one cycle later on the registered outputs
    assign rd_win = (state_q == vlane_pkg::NORMAL_MODE || state_q == vlane_pkg::READ_MODE)
                    && cnt_q < CNT_W'(len_q);
    assign wr_win = state_q == vlane_pkg::NORMAL_MODE
                    && cnt_q >= CNT_W'(delay_q) && cnt_q < wr_end;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q     <= vlane_pkg::IDLE;
            cnt_q       <= '0;
            ready_o     <= 1'b1;
            rd_active_q <= 1'b0;
            wr_active_q <= 1'b0;
            store_q     <= 1'b0;
            load_q      <= 1'b0;
        end else begin
            state_q     <= state_d;
            ready_o     <= state_d == vlane_pkg::IDLE;
            rd_active_q <= rd_win;
            wr_active_q <= wr_win;
            store_q     <= rd_win && state_q == vlane_pkg::READ_MODE;
            load_q      <= state_q == vlane_pkg::LOAD_MODE && state_d == vlane_pkg::LOAD_MODE;
            if (state_q == vlane_pkg::NORMAL_MODE || state_q == vlane_pkg::READ_MODE) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Outputs

    assign rd_active_o        = rd_active_q;
    assign wr_active_o        = wr_active_q;
    assign store_data_valid_o = store_q;
    assign ready_for_load_o   = load_q;
    assign load_phase_o       = load_q;
    assign rd_clear_o         = accept;  // Valid counter takes vl_i at acceptance

    assign actl.load     = accept;  // Start addresses are only stable here
    assign actl.rd_step  = rd_active_q;
    assign actl.wr_step  = wr_active_q || (load_q && load_valid_i);
    assign actl.rd_width = rd_width_q;
    assign actl.wr_width = wr_width_q;

    a_dispatch_kind: assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |-> inst_type_i inside {vlane_pkg::NORMAL, vlane_pkg::STORE, vlane_pkg::LOAD})
        else $error("Dispatched an unknown instruction kind");

    a_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        ready_o |-> !(rd_active_q || wr_active_q || store_q || load_q))
        else $error("ready_o high during an active phase");

endmodule

/* vrf_addr_gen.sv */
`timescale 1ns/1ps

module vrf_addr_gen #(
    parameter int MEM_DEPTH       = vlane_pkg::MEM_DEPTH,
    parameter int MAX_VL_PER_LANE = vlane_pkg::MAX_VL_PER_LANE,
    localparam int AW = $clog2(MEM_DEPTH),
    localparam int RP = vlane_pkg::RD_PORTS
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [AW-1:0]        vrf_start_waddr_i,
    input  logic [RP-1:0][AW-1:0] vrf_start_raddr_i,
    output logic [AW-1:0]        vrf_waddr_o,
    output logic [RP-1:0][AW-1:0] vrf_raddr_o,
    addr_ctrl_if.gen             actl
);

    localparam int CW = $clog2(MAX_VL_PER_LANE) + 1;

    logic [AW-1:0]         wstart_q;
    logic [RP-1:0][AW-1:0] rstart_q;
    logic [CW-1:0]         wcnt_q, rcnt_q;  // Element counts
    logic [AW-1:0]         rd_off;

    // Elements per word, as a right shift of the element count
    function automatic logic [1:0] ew_shift(vlane_pkg::elem_width_e w);
        case (w)
            vlane_pkg::EW_BYTE: return 2'd2;
            vlane_pkg::EW_HALF: return 2'd1;
            default:            return 2'd0;
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (actl.load) begin
            wstart_q <= vrf_start_waddr_i;
            rstart_q <= vrf_start_raddr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wcnt_q <= '0;
            rcnt_q <= '0;
        end else if (actl.load) begin
            wcnt_q <= '0;
            rcnt_q <= '0;
        end else begin
            if (actl.wr_step) wcnt_q <= wcnt_q + 1'b1;
            if (actl.rd_step) rcnt_q <= rcnt_q + 1'b1;  // All read ports together
        end
    end

    assign vrf_waddr_o = wstart_q + AW'(wcnt_q >> ew_shift(actl.wr_width));
    assign rd_off      = AW'(rcnt_q >> ew_shift(actl.rd_width));

    always_comb begin
        for (int p = 0; p < RP; p++) begin
            vrf_raddr_o[p] = rstart_q[p] + rd_off;
        end
    end

endmodule

/* byte_enable_gen.sv */
`timescale 1ns/1ps

module byte_enable_gen #(
    parameter int LANE_NUM = vlane_pkg::LANE_NUM,
    localparam int BPW = vlane_pkg::BYTES_PER_WORD
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          wr_active_i,
    input  vlane_pkg::elem_width_e        wr_width_i,
    input  logic                          load_phase_i,
    input  logic                          load_valid_i,
    input  logic [LANE_NUM-1:0][BPW-1:0]  load_bwen_i,
    output logic [LANE_NUM-1:0][BPW-1:0]  vrf_bwen_o
);

    logic [BPW-1:0] onehot_q;  // Byte slot of the next write
    logic [1:0]     pair_q;    // Half slot of the next write
    logic [BPW-1:0] pattern;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            onehot_q <= BPW'(1);
            pair_q   <= 2'b01;
        end else if (wr_active_i) begin
            onehot_q <= {onehot_q[BPW-2:0], onehot_q[BPW-1]};
            pair_q   <= {pair_q[0], pair_q[1]};
        end else begin
            onehot_q <= BPW'(1);  // Every write burst starts at byte 0
            pair_q   <= 2'b01;
        end
    end

    always_comb begin
        case (wr_width_i)
            vlane_pkg::EW_BYTE: pattern = onehot_q;
            vlane_pkg::EW_HALF: pattern = {{2{pair_q[1]}}, {2{pair_q[0]}}};
            vlane_pkg::EW_WORD: pattern = '1;
            default:            pattern = '0;
        endcase
    end

    // Same pattern on every lane, load unit enables during LOAD
    always_comb begin
        for (int i = 0; i < LANE_NUM; i++) begin
            if (load_phase_i) begin
                vrf_bwen_o[i] = load_valid_i ? load_bwen_i[i] : '0;
            end else begin
                vrf_bwen_o[i] = wr_active_i ? pattern : '0;
            end
        end
    end

    a_byte_onehot: assert property (@(posedge clk_i) disable iff (!rst_i)
        (wr_active_i && wr_width_i == vlane_pkg::EW_BYTE) |-> $onehot(vrf_bwen_o[0]))
        else $error("Byte write enable is not one-hot");

endmodule

/* lane_valid_gen.sv */
`timescale 1ns/1ps

module lane_valid_gen #(
    parameter int LANE_NUM        = vlane_pkg::LANE_NUM,
    parameter int MAX_VL_PER_LANE = vlane_pkg::MAX_VL_PER_LANE,
    localparam int VL_W = $clog2(LANE_NUM * MAX_VL_PER_LANE + 1)
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic [VL_W-1:0]     vl_i,
    input  logic                rd_clear_i,
    input  logic                rd_active_i,
    output logic [LANE_NUM-1:0] read_data_valid_o
);

    logic [VL_W-1:0] remain_q;  // Elements not yet read

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            remain_q <= '0;
        end else if (rd_clear_i) begin
            remain_q <= vl_i;
        end else if (rd_active_i) begin
            // One element per lane each read cycle
            remain_q <= (remain_q > VL_W'(LANE_NUM)) ? remain_q - VL_W'(LANE_NUM) : '0;
        end
    end

    always_comb begin
        for (int i = 0; i < LANE_NUM; i++) begin
            read_data_valid_o[i] = rd_active_i && (remain_q > VL_W'(i));
        end
    end

endmodule

/* lane_driver_top.sv */
`timescale 1ns/1ps

module lane_driver_top #(
    parameter int LANE_NUM        = vlane_pkg::LANE_NUM,
    parameter int MEM_DEPTH       = vlane_pkg::MEM_DEPTH,
    parameter int MAX_VL_PER_LANE = vlane_pkg::MAX_VL_PER_LANE,
    localparam int VL_W = $clog2(LANE_NUM * MAX_VL_PER_LANE + 1),
    localparam int DL_W = $clog2(MAX_VL_PER_LANE),
    localparam int AW   = $clog2(MEM_DEPTH),
    localparam int RP   = vlane_pkg::RD_PORTS,
    localparam int BPW  = vlane_pkg::BYTES_PER_WORD
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    // Handshake and instruction
    input  logic                         start_i,
    output logic                         ready_o,
    input  vlane_pkg::inst_type_e        inst_type_i,
    input  logic [VL_W-1:0]              vl_i,
    input  vlane_pkg::elem_width_e       vsew_i,
    input  vlane_pkg::elem_width_e       wdata_width_i,
    input  logic [DL_W-1:0]              inst_delay_i,
    // VRF
    input  logic [AW-1:0]                vrf_start_waddr_i,
    input  logic [RP-1:0][AW-1:0]        vrf_start_raddr_i,
    output logic [AW-1:0]                vrf_waddr_o,
    output logic [RP-1:0][AW-1:0]        vrf_raddr_o,
    output logic [LANE_NUM-1:0][BPW-1:0] vrf_bwen_o,
    output logic [LANE_NUM-1:0]          read_data_valid_o,
    // Load and store units
    output logic                         store_data_valid_o,
    input  logic                         load_valid_i,
    input  logic                         load_last_i,
    output logic                         ready_for_load_o,
    input  logic [LANE_NUM-1:0][BPW-1:0] load_bwen_i
);

    logic wr_active, load_phase, rd_active, rd_clear;

    addr_ctrl_if actl ();

    lane_sequencer #(.MAX_VL_PER_LANE(MAX_VL_PER_LANE), .LANE_NUM(LANE_NUM)) u_seq (
        .clk_i, .rst_i, .start_i, .inst_type_i, .vl_i, .vsew_i, .wdata_width_i,
        .inst_delay_i, .load_valid_i, .load_last_i, .ready_o, .store_data_valid_o,
        .ready_for_load_o,
        .wr_active_o  (wr_active),
        .load_phase_o (load_phase),
        .rd_active_o  (rd_active),
        .rd_clear_o   (rd_clear),
        .actl         (actl.seq)
    );

    vrf_addr_gen #(.MEM_DEPTH(MEM_DEPTH), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)) u_addr (
        .clk_i, .rst_i, .vrf_start_waddr_i, .vrf_start_raddr_i, .vrf_waddr_o, .vrf_raddr_o,
        .actl (actl.gen)
    );

    byte_enable_gen #(.LANE_NUM(LANE_NUM)) u_bwen (
        .clk_i, .rst_i,
        .wr_active_i  (wr_active),
        .wr_width_i   (actl.wr_width),  // Latched by the sequencer
        .load_phase_i (load_phase),
        .load_valid_i, .load_bwen_i, .vrf_bwen_o
    );

    lane_valid_gen #(.LANE_NUM(LANE_NUM), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)) u_valid (
        .clk_i, .rst_i, .vl_i,
        .rd_clear_i  (rd_clear),
        .rd_active_i (rd_active),
        .read_data_valid_o
    );

endmodule

/* tb_lane_driver.sv */
`timescale 1ns/1ps

module tb_lane_driver;

    localparam int LANE_NUM        = vlane_pkg::LANE_NUM;
    localparam int MEM_DEPTH       = vlane_pkg::MEM_DEPTH;
    localparam int MAX_VL_PER_LANE = vlane_pkg::MAX_VL_PER_LANE;
    localparam int VL_W      = $clog2(LANE_NUM * MAX_VL_PER_LANE + 1);
    localparam int DL_W      = $clog2(MAX_VL_PER_LANE);
    localparam int AW        = $clog2(MEM_DEPTH);
    localparam int RP        = vlane_pkg::RD_PORTS;
    localparam int BPW       = vlane_pkg::BYTES_PER_WORD;
    localparam int NUM_TESTS = 60;

    logic clk_i = 1'b0;
    logic rst_i, start_i, ready_o, load_valid_i, load_last_i;
    logic store_data_valid_o, ready_for_load_o;
    vlane_pkg::inst_type_e        inst_type_i;
    vlane_pkg::elem_width_e       vsew_i, wdata_width_i;
    logic [VL_W-1:0]              vl_i;
    logic [DL_W-1:0]              inst_delay_i;
    logic [AW-1:0]                vrf_start_waddr_i, vrf_waddr_o;
    logic [RP-1:0][AW-1:0]        vrf_start_raddr_i, vrf_raddr_o;
    logic [LANE_NUM-1:0][BPW-1:0] vrf_bwen_o, load_bwen_i;
    logic [LANE_NUM-1:0]          read_data_valid_o;
    logic [31:0]                  rng_state = 32'd94;

    always #5 clk_i = ~clk_i;

    lane_driver_top #(
        .LANE_NUM(LANE_NUM), .MEM_DEPTH(MEM_DEPTH), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)
    ) UUT (
        .clk_i, .rst_i, .start_i, .ready_o, .inst_type_i, .vl_i, .vsew_i, .wdata_width_i,
        .inst_delay_i, .vrf_start_waddr_i, .vrf_start_raddr_i, .vrf_waddr_o, .vrf_raddr_o,
        .vrf_bwen_o, .read_data_valid_o, .store_data_valid_o, .load_valid_i, .load_last_i,
        .ready_for_load_o, .load_bwen_i
    );

    //////////////////////////////////////////////////
    // Helpers and reference model

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic int elem_shift(vlane_pkg::elem_width_e w);
        case (w)
            vlane_pkg::EW_BYTE: return 2;
            vlane_pkg::EW_HALF: return 1;
            default:            return 0;
        endcase
    endfunction

    // Per-lane enables for NORMAL write number j
    function automatic logic [BPW-1:0] byte_pattern(vlane_pkg::elem_width_e w, int j);
        case (w)
            vlane_pkg::EW_BYTE: return 4'b0001 << (j % 4);
            vlane_pkg::EW_HALF: return (j % 2) ? 4'b1100 : 4'b0011;
            default:            return 4'b1111;
        endcase
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // New instruction fields, only taken while ready_o is high
    task automatic scramble_inputs();
        start_i           = (next_rand() % 4) == 0;
        inst_type_i       = vlane_pkg::inst_type_e'(next_rand() % 3);
        vl_i              = VL_W'(next_rand());
        vsew_i            = vlane_pkg::elem_width_e'(next_rand() % 3);
        wdata_width_i     = vlane_pkg::elem_width_e'(next_rand() % 3);
        inst_delay_i      = DL_W'(next_rand());
        vrf_start_waddr_i = AW'(next_rand());
        for (int p = 0; p < RP; p++) vrf_start_raddr_i[p] = AW'(next_rand());
    endtask

    //////////////////////////////////////////////////
    // One instruction, checked cycle by cycle from the acceptance edge

    task automatic run_test();
        vlane_pkg::inst_type_e        kind;
        vlane_pkg::elem_width_e       rdw, wrw;
        logic [AW-1:0]                wstart, exp_waddr;
        logic [RP-1:0][AW-1:0]        rstart, exp_raddr;
        logic [LANE_NUM-1:0][BPW-1:0] exp_bwen;
        logic [LANE_NUM-1:0]          exp_rdv;
        int   vl, len, d, t, end_t, nwr, jl;
        logic rd, wr, in_mode, lwr, done;

        kind = vlane_pkg::inst_type_e'(next_rand() % 3);
        vl   = 1 + next_rand() % (LANE_NUM * MAX_VL_PER_LANE);
        len  = (vl + LANE_NUM - 1) / LANE_NUM;
        d    = 1 + next_rand() % ((1 << DL_W) - 1);
        nwr  = 1 + next_rand() % 48;  // LOAD writes

        @(posedge clk_i);
        #1;
        scramble_inputs();
        start_i      = 1'b1;
        inst_type_i  = kind;
        vl_i         = VL_W'(vl);
        inst_delay_i = DL_W'(d);
        rdw    = (kind == vlane_pkg::STORE) ? vlane_pkg::EW_WORD : vsew_i;
        wrw    = (kind == vlane_pkg::LOAD) ? vlane_pkg::EW_WORD : wdata_width_i;
        wstart = vrf_start_waddr_i;
        rstart = vrf_start_raddr_i;
        @(negedge clk_i);
        compare(ready_o, 1'b1, "ready_o before start");

        t     = -2;  // DISPATCH cycle, mode cycle 0 comes two cycles later
        jl    = 0;
        done  = 1'b0;
        end_t = (kind == vlane_pkg::NORMAL) ? d + len :
                (kind == vlane_pkg::STORE)  ? len : 32'h3fff_ffff;
        while (!done) begin
            @(posedge clk_i);
            #1;
            if (t == end_t) start_i = 1'b0;
            else scramble_inputs();  // Start pulses here must be ignored
            load_valid_i = (next_rand() % 4) != 0;
            for (int i = 0; i < LANE_NUM; i++) load_bwen_i[i] = BPW'(next_rand());
            in_mode     = t >= 0 && t < end_t;
            lwr         = kind == vlane_pkg::LOAD && in_mode && load_valid_i;
            load_last_i = lwr && (jl + 1 == nwr);
            @(negedge clk_i);

            rd = kind != vlane_pkg::LOAD && t >= 0 && t < len;
            wr = kind == vlane_pkg::NORMAL && t >= d && t < d + len;
            for (int i = 0; i < LANE_NUM; i++) begin
                exp_rdv[i]  = rd && (t * LANE_NUM + i < vl);
                exp_bwen[i] = wr ? byte_pattern(wrw, t - d) : (lwr ? load_bwen_i[i] : '0);
            end
            compare(ready_o, t == end_t, "ready_o");
            compare(store_data_valid_o, kind == vlane_pkg::STORE && rd, "store_data_valid_o");
            compare(ready_for_load_o, kind == vlane_pkg::LOAD && in_mode, "ready_for_load_o");
            compare(read_data_valid_o, exp_rdv, "read_data_valid_o");
            compare(vrf_bwen_o, exp_bwen, "vrf_bwen_o");
            if (rd) begin
                for (int p = 0; p < RP; p++) exp_raddr[p] = rstart[p] + AW'(t >> elem_shift(rdw));
                compare(vrf_raddr_o, exp_raddr, "vrf_raddr_o");
            end
            if (wr || lwr) begin
                exp_waddr = wr ? wstart + AW'((t - d) >> elem_shift(wrw)) : wstart + AW'(jl);
                compare(vrf_waddr_o, exp_waddr, "vrf_waddr_o");
            end

            if (t == end_t) done = 1'b1;
            if (lwr) begin
                jl++;
                if (jl == nwr) end_t = t + 1;  // Mode ends after the last flag
            end
            t++;
        end
    endtask

    initial begin
        rst_i        = 1'b0;
        start_i      = 1'b0;
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        load_bwen_i  = '0;
        scramble_inputs();
        start_i = 1'b0;
        repeat (16) @(posedge clk_i);
        #1 rst_i = 1'b1;
        @(negedge clk_i);
        compare(ready_o, 1'b1, "ready_o after reset");
        compare(vrf_bwen_o, '0, "vrf_bwen_o after reset");
        compare(read_data_valid_o, '0, "read_data_valid_o after reset");
        compare(store_data_valid_o, 1'b0, "store_data_valid_o after reset");
        compare(ready_for_load_o, 1'b0, "ready_for_load_o after reset");
        for (int n = 0; n < NUM_TESTS; n++) run_test();
        $display("STATUS: PASS");
        $finish;
    end

    // Longest instruction is bounded by the delay plus the read length
    initial begin
        repeat (NUM_TESTS * (2 * MAX_VL_PER_LANE + 40) + 16) @(posedge clk_i);
        $display("Watchdog expired, the DUT hung");
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped by the watchdog");
    end

endmodule

/* list.f */
vlane_pkg.sv
addr_ctrl_if.sv
lane_sequencer.sv
vrf_addr_gen.sv
byte_enable_gen.sv
lane_valid_gen.sv
lane_driver_top.sv
tb_lane_driver.sv
